// File: source/core_pkg.sv
`default_nettype none

package core_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0] reg_addr_t;
    typedef logic [6:0] opcode_t;

    localparam word_t RESET_PC = 32'h0000_0000;

    // base opcodes of the supported subset
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_REG    = 7'b0110011;

    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [2:0] F3_ADD = 3'b000; // also addi.
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_SW  = 3'b010;

endpackage

`default_nettype wire

// File: source/decode_if.sv
`timescale 1ns/1ps
`default_nettype none

interface decode_if;

    import core_pkg::*;

    word_t      pc;
    opcode_t    opcode;
    logic [2:0] funct3;
    word_t      imm;       // sign extended, format picked by opcode.
    word_t      rs1_data;
    word_t      rs2_data;

    modport dec (
        output pc,
        output opcode,
        output funct3,
        output imm,
        output rs1_data,
        output rs2_data
    );

    modport exe (
        input pc,
        input opcode,
        input funct3,
        input imm,
        input rs1_data,
        input rs2_data
    );

endinterface

`default_nettype wire

// File: source/mux_key_with_default.sv
`timescale 1ns/1ps
`default_nettype none

module mux_key_with_default #(
    parameter int NR_KEY   = 2,
    parameter int KEY_LEN  = 1,
    parameter int DATA_LEN = 1
) (
    output logic [DATA_LEN-1:0]                  out,
    input  wire logic [KEY_LEN-1:0]              key,
    input  wire logic [DATA_LEN-1:0]             default_out,
    input  wire logic [NR_KEY*(KEY_LEN+DATA_LEN)-1:0] lut
);

    localparam int PAIR_LEN = KEY_LEN + DATA_LEN;

    logic hit;

    // pairs are packed key then value, first pair in the top bits.
    always_comb begin
        out = default_out;
        hit = 1'b0;
        for (int i = NR_KEY - 1; i >= 0; i--) begin
            if (!hit && lut[i*PAIR_LEN+DATA_LEN +: KEY_LEN] == key) begin
                out = lut[i*PAIR_LEN +: DATA_LEN];
                hit = 1'b1; // first listed pair wins.
            end
        end
    end

endmodule

`default_nettype wire

// File: source/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  wire logic                clk,
    input  wire logic                arst_n,
    input  wire core_pkg::reg_addr_t rs1_addr,
    input  wire core_pkg::reg_addr_t rs2_addr,
    output core_pkg::word_t          rs1_data,
    output core_pkg::word_t          rs2_data,
    input  wire core_pkg::reg_addr_t rd_addr,
    input  wire logic                reg_write_en,
    input  wire core_pkg::word_t     wdata
);

    import core_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_write_en && rd_addr != '0) begin
            regs[rd_addr] <= wdata; // x0 writes dropped.
        end
    end

    // combinational read, x0 hardwired.
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

// File: source/idu.sv
`timescale 1ns/1ps
`default_nettype none

module idu (
    input  wire logic                clk,
    input  wire logic                arst_n,
    input  wire core_pkg::word_t     next_pc,
    input  wire core_pkg::word_t     inst,
    output core_pkg::word_t          inst_addr,
    output core_pkg::reg_addr_t      rs1_addr,
    output core_pkg::reg_addr_t      rs2_addr,
    input  wire core_pkg::word_t     rs1_data,
    input  wire core_pkg::word_t     rs2_data,
    output core_pkg::reg_addr_t      rd_addr,
    output logic                     reg_write_en,
    decode_if.dec                    dec
);

    import core_pkg::*;

    word_t      pc;
    opcode_t    opcode;
    logic [2:0] funct3;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    word_t      imm;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= RESET_PC;
        end else begin
            pc <= next_pc; // one instruction per cycle.
        end
    end

    assign inst_addr = pc;

    assign opcode   = inst[6:0];
    assign rd_addr  = inst[11:7];
    assign funct3   = inst[14:12];
    assign rs1_addr = inst[19:15];
    assign rs2_addr = inst[24:20];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // I format covers jalr, loads and op-imm.
    mux_key_with_default #(
        .NR_KEY   (5),
        .KEY_LEN  (7),
        .DATA_LEN (XLEN)
    ) i_imm_select (
        .out         (imm),
        .key         (opcode),
        .default_out (imm_i),
        .lut         ({
            OP_STORE,  imm_s,
            OP_BRANCH, imm_b,
            OP_LUI,    imm_u,
            OP_AUIPC,  imm_u,
            OP_JAL,    imm_j
        })
    );

    // unknown opcodes never write.
    assign reg_write_en = opcode inside {OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
                                         OP_LOAD, OP_IMM, OP_REG};

    assign dec.pc       = pc;
    assign dec.opcode   = opcode;
    assign dec.funct3   = funct3;
    assign dec.imm      = imm;
    assign dec.rs1_data = rs1_data;
    assign dec.rs2_data = rs2_data;

endmodule

`default_nettype wire

// File: source/exu.sv
`timescale 1ns/1ps
`default_nettype none

module exu (
    decode_if.exe                dec,
    input  wire core_pkg::word_t mem_rdata,
    output core_pkg::word_t      result,
    output core_pkg::word_t      next_pc,
    output core_pkg::word_t      mem_addr,
    output core_pkg::word_t      mem_wdata,
    output logic                 mem_wen
);

    import core_pkg::*;

    word_t alu_a;
    word_t alu_b;
    word_t alu_out;
    word_t pc_plus_4;
    word_t pc_plus_imm;
    word_t jalr_target;
    word_t branch_next;
    logic  rs_equal;
    logic  branch_taken;

    mux_key_with_default #(
        .NR_KEY   (3),
        .KEY_LEN  (7),
        .DATA_LEN (XLEN)
    ) i_alu_a_select (
        .out         (alu_a),
        .key         (dec.opcode),
        .default_out (dec.rs1_data),
        .lut         ({
            OP_AUIPC, dec.pc,
            OP_LUI,   {XLEN{1'b0}},
            OP_JAL,   dec.pc
        })
    );

    mux_key_with_default #(
        .NR_KEY   (2),
        .KEY_LEN  (7),
        .DATA_LEN (XLEN)
    ) i_alu_b_select (
        .out         (alu_b),
        .key         (dec.opcode),
        .default_out (dec.imm),
        .lut         ({
            OP_REG,    dec.rs2_data,
            OP_BRANCH, dec.rs2_data
        })
    );

    assign alu_out = alu_a + alu_b; // the only adder for data and addresses.

    assign pc_plus_4   = dec.pc + 32'd4;
    assign pc_plus_imm = dec.pc + dec.imm;
    assign jalr_target = alu_out & ~32'h1; // rs1 + imm, bit 0 cleared.

    assign rs_equal     = (dec.rs1_data == dec.rs2_data);
    assign branch_taken = (dec.funct3 == F3_BEQ &&  rs_equal) ||
                          (dec.funct3 == F3_BNE && !rs_equal);
    assign branch_next  = branch_taken ? pc_plus_imm : pc_plus_4;

    mux_key_with_default #(
        .NR_KEY   (3),
        .KEY_LEN  (7),
        .DATA_LEN (XLEN)
    ) i_result_select (
        .out         (result),
        .key         (dec.opcode),
        .default_out (alu_out),
        .lut         ({
            OP_JAL,  pc_plus_4,
            OP_JALR, pc_plus_4,
            OP_LOAD, mem_rdata
        })
    );

    mux_key_with_default #(
        .NR_KEY   (3),
        .KEY_LEN  (7),
        .DATA_LEN (XLEN)
    ) i_next_pc_select (
        .out         (next_pc),
        .key         (dec.opcode),
        .default_out (pc_plus_4),
        .lut         ({
            OP_JAL,    pc_plus_imm,
            OP_JALR,   jalr_target,
            OP_BRANCH, branch_next
        })
    );

    // word access only.
    assign mem_addr  = alu_out;
    assign mem_wdata = dec.rs2_data;
    assign mem_wen   = (dec.opcode == OP_STORE);

endmodule

`default_nettype wire

// File: source/rv32_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv32_core (
    input  wire logic            clk,
    input  wire logic            arst_n,
    output core_pkg::word_t      inst_addr,
    input  wire core_pkg::word_t inst,
    output core_pkg::word_t      mem_addr,
    input  wire core_pkg::word_t mem_rdata,
    output core_pkg::word_t      mem_wdata,
    output logic                 mem_wen
);

    import core_pkg::*;

    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    reg_addr_t rd_addr;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     result;
    word_t     next_pc;
    logic      reg_write_en;

    decode_if dec_bus ();

    regfile i_regfile (
        .clk          (clk),
        .arst_n       (arst_n),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .rd_addr      (rd_addr),
        .reg_write_en (reg_write_en),
        .wdata        (result)
    );

    idu i_idu (
        .clk          (clk),
        .arst_n       (arst_n),
        .next_pc      (next_pc),
        .inst         (inst),
        .inst_addr    (inst_addr),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .rd_addr      (rd_addr),
        .reg_write_en (reg_write_en),
        .dec          (dec_bus.dec)
    );

    exu i_exu (
        .dec       (dec_bus.exe),
        .mem_rdata (mem_rdata),
        .result    (result),
        .next_pc   (next_pc),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_wen   (mem_wen)
    );

endmodule

`default_nettype wire

// File: test/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter real PERIOD       = 20.0,
    parameter int  RESET_CYCLES = 3
) (
    input  wire logic reset_req,
    output logic      clk,
    output logic      arst_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2.0);
            clk = ~clk;
        end
    end

    // low at start and again on every request.
    initial begin
        arst_n = 1'b0;
        forever begin
            repeat (RESET_CYCLES) @(posedge clk);
            arst_n <= 1'b1;
            @(posedge reset_req);
            arst_n <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: test/tb_rv32_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv32_core;

    import core_pkg::*;

    localparam int    BODY_LEN   = 150;
    localparam int    MAX_CYCLES = 3000; // six tests of 250 cycles with a 2x margin.
    localparam word_t HALT       = {25'b0, OP_JAL}; // jal x0, 0 spins in place.

    logic        clk;
    logic        arst_n;
    logic        reset_req;
    logic        preload;
    word_t       inst_addr;
    word_t       inst;
    word_t       mem_addr;
    word_t       mem_rdata;
    word_t       mem_wdata;
    logic        mem_wen;
    word_t       imem [256] = '{default: '0};
    word_t       dmem [64] = '{default: '0};
    word_t       prog [256];
    word_t       m_pc;
    word_t       m_regs [32];
    word_t       m_dmem [64];
    logic [31:0] rng;
    int          cycles = 0;
    int          errors;
    int          passed;
    int          failed;

    tb_clock #(
        .PERIOD       (20.0),
        .RESET_CYCLES (3)
    ) i_clock (
        .reset_req (reset_req),
        .clk       (clk),
        .arst_n    (arst_n)
    );

    rv32_core i_rv32_core (
        .clk       (clk),
        .arst_n    (arst_n),
        .inst_addr (inst_addr),
        .inst      (inst),
        .mem_addr  (mem_addr),
        .mem_rdata (mem_rdata),
        .mem_wdata (mem_wdata),
        .mem_wen   (mem_wen)
    );

    assign inst      = imem[inst_addr[9:2]];
    assign mem_rdata = dmem[mem_addr[7:2]];

    always @(posedge clk) begin
        if (preload) begin
            for (int a = 0; a < 64; a++) begin
                dmem[a] <= fill_word(a);
            end
        end else if (arst_n && mem_wen) begin
            dmem[mem_addr[7:2]] <= mem_wdata;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles.", MAX_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic int rand_below(input int n);
        rng = xorshift(rng);
        return int'(rng % 32'(n));
    endfunction

    function automatic word_t fill_word(input int a);
        return (32'(a) * 32'h9e37_79b9) ^ 32'h5a5a_a5a5; // odd multiplier keeps words unique.
    endfunction

    function automatic word_t i_type(input opcode_t op, input logic [2:0] f3, input int rd,
                                     input int rs1, input int imm);
        return {12'(imm), 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic word_t s_type(input int rs2, input int rs1, input int imm);
        logic [11:0] v;
        v = 12'(imm);
        return {v[11:5], 5'(rs2), 5'(rs1), F3_SW, v[4:0], OP_STORE};
    endfunction

    function automatic word_t b_type(input logic [2:0] f3, input int rs1, input int rs2,
                                     input int imm);
        logic [12:0] v;
        v = 13'(imm);
        return {v[12], v[10:5], 5'(rs2), 5'(rs1), f3, v[4:1], v[11], OP_BRANCH};
    endfunction

    function automatic word_t j_type(input int rd, input int imm);
        logic [20:0] v;
        v = 21'(imm);
        return {v[20], v[10:1], v[11], v[19:12], 5'(rd), OP_JAL};
    endfunction

    function automatic word_t random_arith();
        int    rd;
        word_t w;
        rd = rand_below(32);
        case (rand_below(4))
            0: w = {7'b0, 5'(rand_below(32)), 5'(rand_below(32)), F3_ADD, 5'(rd), OP_REG};
            1: w = i_type(OP_IMM, F3_ADD, rd, rand_below(32), rand_below(4096) - 2048);
            2: w = {20'(rand_below(1 << 20)), 5'(rd), OP_LUI};
            default: w = {20'(rand_below(1 << 20)), 5'(rd), OP_AUIPC};
        endcase
        return w;
    endfunction

    // all control flow goes forward, so every program reaches the halt.
    task automatic build_program(input int kind);
        int   i;
        int   k;
        int   t;
        int   rb;
        int   off;
        int   base;
        logic jump_to [256];
        for (int a = 0; a < 256; a++) begin
            prog[a]    = HALT;
            jump_to[a] = 1'b0;
        end
        i = 0;
        while (kind != 0 && i < BODY_LEN) begin
            k = 1 + rand_below(4);
            if (i + k > BODY_LEN) begin
                k = BODY_LEN - i;
            end
            rb  = 1 + rand_below(31);
            off = 4 * rand_below(64);
            case (kind)
                1: prog[i] = random_arith();
                2: begin
                    if (rand_below(2) == 0) begin
                        prog[i] = b_type(rand_below(2) == 0 ? F3_BEQ : F3_BNE,
                                         rand_below(8), rand_below(8), 4 * k);
                    end else begin
                        prog[i] = i_type(OP_IMM, F3_ADD, rand_below(8), 0, rand_below(3));
                    end
                end
                3: begin
                    t = rand_below(3);
                    if (t == 0) begin
                        prog[i] = j_type(rand_below(32), 4 * k);
                        jump_to[i + k] = 1'b1;
                    end else if (t == 1 && i + 1 < BODY_LEN && !jump_to[i + 1]) begin
                        t   = (i + 1 + k > BODY_LEN) ? BODY_LEN : i + 1 + k;
                        off = rand_below(16) - 8;
                        // base plus offset may come out odd.
                        prog[i] = i_type(OP_IMM, F3_ADD, rb, 0, 4 * t - off + rand_below(2));
                        prog[i + 1] = i_type(OP_JALR, F3_ADD, rand_below(32), rb, off);
                        jump_to[t] = 1'b1;
                        i++;
                    end else begin
                        prog[i] = random_arith();
                    end
                end
                4: begin
                    t = rand_below(4);
                    if (t == 0) begin
                        prog[i] = s_type(rand_below(32), 0, off);
                    end else if (t == 1) begin
                        prog[i] = i_type(OP_LOAD, F3_LW, rand_below(32), 0, off);
                    end else if (t == 2 && i + 1 < BODY_LEN) begin
                        base = 4 * rand_below(64);
                        prog[i] = i_type(OP_IMM, F3_ADD, rb, 0, base);
                        if (rand_below(2) == 0) begin
                            prog[i + 1] = s_type(rand_below(32), rb, off - base);
                        end else begin
                            prog[i + 1] = i_type(OP_LOAD, F3_LW, rand_below(32), rb, off - base);
                        end
                        i++;
                    end else begin
                        prog[i] = random_arith();
                    end
                end
                default: begin
                    if (rand_below(2) == 0) begin
                        prog[i] = random_arith();
                    end else begin
                        do begin
                            rng = xorshift(rng);
                        end while (rng[6:0] inside {OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
                                   OP_BRANCH, OP_LOAD, OP_STORE, OP_IMM, OP_REG});
                        prog[i] = rng;
                    end
                end
            endcase
            i++;
        end
        for (int r = 1; r < 32; r++) begin
            prog[i + r - 1] = s_type(r, 0, 4 * r); // dump of every register.
        end
    endtask

    task automatic report_mismatch(input string what, input word_t expected, input word_t actual);
        $display("Mismatch at time %0t: %s expected %08h, got %08h",
                 $time, what, expected, actual);
        errors++;
    endtask

    // reference model, one instruction per call.
    task automatic step_and_check();
        word_t ins;
        word_t a;
        word_t b;
        word_t imm_i;
        word_t nxt;
        word_t wval;
        word_t addr;
        logic  wr;
        logic  st;
        ins   = prog[m_pc[9:2]];
        a     = m_regs[ins[19:15]];
        b     = m_regs[ins[24:20]];
        imm_i = 32'($signed(ins[31:20]));
        nxt   = m_pc + 32'd4;
        wval  = m_pc + 32'd4;
        addr  = a + 32'($signed({ins[31:25], ins[11:7]}));
        wr    = 1'b1;
        st    = 1'b0;
        case (ins[6:0])
            OP_LUI:   wval = {ins[31:12], 12'h000};
            OP_AUIPC: wval = m_pc + {ins[31:12], 12'h000};
            OP_JAL:   nxt = m_pc + 32'($signed({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0}));
            OP_JALR:  nxt = (a + imm_i) & ~32'h1;
            OP_BRANCH: begin
                wr = 1'b0;
                if ((ins[14:12] == F3_BEQ && a == b) || (ins[14:12] == F3_BNE && a != b)) begin
                    nxt = m_pc + 32'($signed({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0}));
                end
            end
            OP_LOAD: begin
                addr = a + imm_i;
                wval = m_dmem[addr[7:2]];
            end
            OP_STORE: begin
                wr = 1'b0;
                st = 1'b1;
            end
            OP_IMM:  wval = a + imm_i;
            OP_REG:  wval = a + b;
            default: wr = 1'b0; // no effect at all.
        endcase
        if (inst_addr !== m_pc) begin
            report_mismatch("inst_addr", m_pc, inst_addr);
        end
        if (mem_wen !== st) begin
            report_mismatch("mem_wen", 32'(st), 32'(mem_wen));
        end
        if (st && mem_addr !== addr) begin
            report_mismatch("store address", addr, mem_addr);
        end
        if (st && mem_wdata !== b) begin
            report_mismatch("store data", b, mem_wdata);
        end
        if (wr && ins[11:7] != 5'd0) begin
            m_regs[ins[11:7]] = wval;
        end
        if (st) begin
            m_dmem[addr[7:2]] = b;
        end
        m_pc = nxt;
    endtask

    task automatic run_test(input string name, input int kind);
        int err_start;
        int steps;
        err_start = errors;
        steps     = 0;
        build_program(kind);
        @(posedge clk);
        reset_req <= 1'b1;
        preload   <= 1'b1;
        for (int a = 0; a < 256; a++) begin
            imem[a] <= prog[a];
        end
        @(posedge clk);
        reset_req <= 1'b0;
        preload   <= 1'b0;
        m_pc = RESET_PC;
        for (int a = 0; a < 64; a++) begin
            m_dmem[a] = fill_word(a);
        end
        for (int r = 0; r < 32; r++) begin
            m_regs[r] = '0;
        end
        @(posedge arst_n);
        @(negedge clk);
        if (inst_addr !== RESET_PC) begin
            report_mismatch("pc after reset", RESET_PC, inst_addr);
        end
        while (prog[m_pc[9:2]] != HALT) begin
            step_and_check();
            steps++;
            @(negedge clk);
        end
        if (inst_addr !== m_pc) begin
            report_mismatch("pc at halt", m_pc, inst_addr);
        end
        if (errors == err_start) begin
            passed++;
        end else begin
            failed++;
        end
        $display("test %-8s %s after %0d instructions, %0d mismatches", name,
                 (errors == err_start) ? "passed" : "failed", steps, errors - err_start);
    endtask

    initial begin
        rng       = 32'h567b;
        errors    = 0;
        passed    = 0;
        failed    = 0;
        reset_req = 1'b0;
        preload   = 1'b0;
        run_test("reset", 0);
        run_test("arith", 1);
        run_test("branch", 2);
        run_test("jump", 3);
        run_test("memory", 4);
        run_test("unknown", 5);
        $display("tests passed %0d, failed %0d, mismatches %0d", passed, failed, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rv32_core.f
source/core_pkg.sv
source/decode_if.sv
source/mux_key_with_default.sv
source/regfile.sv
source/idu.sv
source/exu.sv
source/rv32_core.sv
test/tb_clock.sv
test/tb_rv32_core.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --timescale 1ns/1ps \
    --top-module tb_rv32_core \
    -f rv32_core.f \
    -o sim_rv32_core

out="$(./obj_dir/sim_rv32_core)"
echo "$out"
echo "$out" | grep -qx "NO ERRORS"
